/* dz_pkg.sv */
`default_nettype none

package dz_pkg;

    // digit codes
    localparam int DIGIT_W = 3;
    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 3'd5;
    localparam logic [DIGIT_W-1:0] DIGIT_BLANK = 3'd7;  // 6 is dark as well

    // panel geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;

    localparam int DIV_W = 16;

    // register map
    localparam int CFG_ADDR_W = 2;
    localparam logic [CFG_ADDR_W-1:0] REG_SCAN_DIV = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_SEC_DIV = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_START = 2'd2;

    // reset defaults
    localparam logic [DIV_W-1:0] SCAN_DIV_RST = 16'd49;
    localparam logic [DIV_W-1:0] SEC_DIV_RST = 16'd49999;
    localparam logic [DIGIT_W-1:0] START_RST = 3'd5;

endpackage

`default_nettype wire

/* dz_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module dz_cfg_regs (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         cfg_we,
    input  wire logic [dz_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  wire logic [15:0]                  cfg_wdata,
    output logic      [dz_pkg::DIV_W-1:0]     scan_div,
    output logic      [dz_pkg::DIV_W-1:0]     sec_div,
    output logic      [dz_pkg::DIGIT_W-1:0]   start_digit
);

    import dz_pkg::*;

    logic start_over;

    // nothing above 5 can be drawn
    assign start_over = cfg_wdata > 16'(DIGIT_MAX);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_div    <= SCAN_DIV_RST;
            sec_div     <= SEC_DIV_RST;
            start_digit <= START_RST;
        end
        else if (cfg_we)
        begin
            case (cfg_addr)
                REG_SCAN_DIV: scan_div <= cfg_wdata;
                REG_SEC_DIV:  sec_div <= cfg_wdata;
                REG_START:
                begin
                    if (start_over)
                        start_digit <= DIGIT_MAX;
                    else
                        start_digit <= cfg_wdata[DIGIT_W-1:0];
                end
                default: ;  // addr 3 unused
            endcase
        end
    end

endmodule

`default_nettype wire

/* dz_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module dz_tick_gen (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     start,
    input  wire logic [dz_pkg::DIV_W-1:0] scan_div,
    input  wire logic [dz_pkg::DIV_W-1:0] sec_div,
    output logic                          scan_tick,
    output logic                          sec_tick
);

    import dz_pkg::*;

    logic [DIV_W-1:0] scan_cnt;
    logic [DIV_W-1:0] sec_cnt;

    // >= so a smaller divider written mid-count wraps at once
    assign scan_tick = scan_cnt >= scan_div;
    assign sec_tick  = sec_cnt >= sec_div;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan_cnt <= '0;
        else if (scan_tick)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // phase restarts on start so the first digit gets a full second
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sec_cnt <= '0;
        else if (start || sec_tick)
            sec_cnt <= '0;
        else
            sec_cnt <= sec_cnt + 1'b1;
    end

endmodule

`default_nettype wire

/* dz_countdown.sv */
`timescale 1ns/1ps
`default_nettype none

module dz_countdown (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       start,
    input  wire logic                       sec_tick,
    input  wire logic [dz_pkg::DIGIT_W-1:0] start_digit,
    output logic      [dz_pkg::DIGIT_W-1:0] digit,
    output logic                            done
);

    import dz_pkg::*;

    logic running;
    logic at_zero;

    assign at_zero = digit == '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            running <= 1'b0;
            digit   <= DIGIT_BLANK;  // panel dark until first start
            done    <= 1'b0;
        end
        else if (start)
        begin
            // also a restart when already counting
            running <= 1'b1;
            digit   <= start_digit;
            done    <= 1'b0;
        end
        else if (running && sec_tick)
        begin
            if (at_zero)
            begin
                running <= 1'b0;
                done    <= 1'b1;  // 0 has had its full second
            end
            else
            begin
                digit <= digit - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* dz_glyph_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module dz_glyph_rom (
    input  wire logic [dz_pkg::DIGIT_W-1:0] digit,
    input  wire logic [2:0]                 row_idx,
    output logic      [dz_pkg::COLS-1:0]    colr,
    output logic      [dz_pkg::COLS-1:0]    colg
);

    import dz_pkg::*;

    logic [ROWS*COLS-1:0] font_bits;  // row 0 in the top byte
    logic [COLS-1:0]      glyph;
    logic                 use_red;
    logic                 use_green;

    always_comb
    begin
        case (digit)
            3'd0:    font_bits = 64'h3C42_4242_4242_3C00;
            3'd1:    font_bits = 64'h1838_1818_1818_7E00;
            3'd2:    font_bits = 64'h3C66_060C_3060_7E00;
            3'd3:    font_bits = 64'h3C66_061C_0666_3C00;
            3'd4:    font_bits = 64'h0C1C_2C4C_7E0C_0C00;
            3'd5:    font_bits = 64'h7E60_7C06_0666_3C00;
            default: font_bits = '0;  // 6 and 7 blank
        endcase
    end

    assign glyph = font_bits[COLS*(ROWS-1-int'(row_idx)) +: COLS];

    // red 5,4 / yellow 3,2 / green 1,0
    always_comb
    begin
        case (digit)
            3'd5, 3'd4:
            begin
                use_red   = 1'b1;
                use_green = 1'b0;
            end
            3'd3, 3'd2:
            begin
                use_red   = 1'b1;
                use_green = 1'b1;
            end
            3'd1, 3'd0:
            begin
                use_red   = 1'b0;
                use_green = 1'b1;
            end
            default:
            begin
                use_red   = 1'b0;
                use_green = 1'b0;
            end
        endcase
    end

    assign colr = use_red ? glyph : '0;
    assign colg = use_green ? glyph : '0;

endmodule

`default_nettype wire

/* dz_show.sv */
`timescale 1ns/1ps
`default_nettype none

module dz_show (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       scan_tick,
    input  wire logic [dz_pkg::DIGIT_W-1:0] digit,
    output logic      [dz_pkg::ROWS-1:0]    row,
    output logic      [dz_pkg::COLS-1:0]    colr,
    output logic      [dz_pkg::COLS-1:0]    colg
);

    import dz_pkg::*;

    logic [2:0]         row_idx;
    logic [DIGIT_W-1:0] shown;
    logic [COLS-1:0]    rom_r;
    logic [COLS-1:0]    rom_g;
    logic               blank;
    logic [ROWS-1:0]    row_sel;

    dz_glyph_rom u_rom (
        .digit   (shown),
        .row_idx (row_idx),
        .colr    (rom_r),
        .colg    (rom_g)
    );

    assign blank   = shown > DIGIT_MAX;
    assign row_sel = {{(ROWS-1){1'b0}}, 1'b1} << row_idx;

    // row index and frame latch
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
            shown   <= DIGIT_BLANK;
        end
        else if (scan_tick)
        begin
            row_idx <= row_idx + 1'b1;  // wraps 7 -> 0
            if (row_idx == 3'd7)
                shown <= digit;  // new digit only at frame start
        end
    end

    // row and columns leave on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= blank ? '1 : ~row_sel;  // no row driven while dark
            colr <= rom_r;
            colg <= rom_g;
        end
    end

endmodule

`default_nettype wire

/* dz_countdown_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dz_countdown_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          cfg_we,
    input  wire logic [dz_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  wire logic [15:0]                   cfg_wdata,
    input  wire logic                          start,
    output logic      [dz_pkg::ROWS-1:0]       row,
    output logic      [dz_pkg::COLS-1:0]       colr,
    output logic      [dz_pkg::COLS-1:0]       colg,
    output logic      [dz_pkg::DIGIT_W-1:0]    digit,
    output logic                               done
);

    import dz_pkg::*;

    logic [DIV_W-1:0]   scan_div;
    logic [DIV_W-1:0]   sec_div;
    logic [DIGIT_W-1:0] start_digit;
    logic               scan_tick;
    logic               sec_tick;

    dz_cfg_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .scan_div    (scan_div),
        .sec_div     (sec_div),
        .start_digit (start_digit)
    );

    dz_tick_gen u_ticks (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .scan_div  (scan_div),
        .sec_div   (sec_div),
        .scan_tick (scan_tick),
        .sec_tick  (sec_tick)
    );

    dz_countdown u_count (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .sec_tick    (sec_tick),
        .start_digit (start_digit),
        .digit       (digit),
        .done        (done)
    );

    // display follows the counter
    dz_show u_show (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .digit     (digit),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

`default_nettype wire

/* tb_dz_countdown.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dz_countdown;

    import dz_pkg::*;

    localparam int RUNS = 6;
    localparam int CYCLE_LIMIT = RUNS * (7 * 121 + 60);  // 6 digits + restart + writes

    logic        clk;
    logic        rst;
    logic        cfg_we;
    logic [1:0]  cfg_addr;
    logic [15:0] cfg_wdata;
    logic        start;
    logic [7:0]  row;
    logic [7:0]  colr;
    logic [7:0]  colg;
    logic [2:0]  digit;
    logic        done;

    integer seed;
    integer errors;
    integer checks;
    integer cycles;

    // reference model state
    logic [7:0]  font [0:63];  // digit*8 + row
    logic [15:0] m_scan_div, m_sec_div, m_scan_cnt, m_sec_cnt;
    logic [2:0]  m_start, m_digit, m_idx, m_shown;
    logic        m_running, m_done;
    logic [7:0]  m_row, m_colr, m_colg;
    logic        m_scan_hit;
    logic        m_sec_hit;
    logic [1:0]  m_colour;

    dz_countdown_top uut (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .start     (start),
        .row       (row),
        .colr      (colr),
        .colg      (colg),
        .digit     (digit),
        .done      (done)
    );

    always #20 clk = ~clk;

    // {red, green} for each digit
    function automatic logic [1:0] colour_of(input logic [2:0] d);
        if (d == 3'd4 || d == 3'd5)
            return 2'b10;
        else if (d == 3'd2 || d == 3'd3)
            return 2'b11;
        else if (d <= 3'd1)
            return 2'b01;
        return 2'b00;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic load_glyph(input int d, input logic [63:0] g);
        int r;
    begin
        for (r = 0; r < 8; r++)
            font[d * 8 + r] = g[63 - 8 * r -: 8];  // top row first
    end
    endtask

    task automatic wait_cycle;
    begin
        @(posedge clk);
        #2;
    end
    endtask

    task automatic write_reg(input logic [1:0] addr, input int data);
    begin
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data[15:0];
        wait_cycle();
        cfg_we = 1'b0;
    end
    endtask

    task automatic pulse_start;
    begin
        start = 1'b1;
        wait_cycle();
        start = 1'b0;
    end
    endtask

    assign m_scan_hit = m_scan_cnt >= m_scan_div;
    assign m_sec_hit  = m_sec_cnt >= m_sec_div;
    assign m_colour   = colour_of(m_shown);

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_scan_div <= SCAN_DIV_RST;
            m_sec_div  <= SEC_DIV_RST;
            m_start    <= START_RST;
            m_scan_cnt <= '0;
            m_sec_cnt  <= '0;
            m_running  <= 1'b0;
            m_digit    <= DIGIT_BLANK;
            m_done     <= 1'b0;
            m_idx      <= '0;
            m_shown    <= DIGIT_BLANK;
            m_row      <= 8'hff;
            m_colr     <= '0;
            m_colg     <= '0;
        end
        else
        begin
            if (cfg_we && cfg_addr == 2'd0)
                m_scan_div <= cfg_wdata;
            if (cfg_we && cfg_addr == 2'd1)
                m_sec_div <= cfg_wdata;
            if (cfg_we && cfg_addr == 2'd2)
                m_start <= (cfg_wdata > 16'd5) ? 3'd5 : cfg_wdata[2:0];
            m_scan_cnt <= m_scan_hit ? 16'd0 : m_scan_cnt + 16'd1;
            m_sec_cnt  <= (start || m_sec_hit) ? 16'd0 : m_sec_cnt + 16'd1;
            if (start)
            begin
                m_running <= 1'b1;
                m_digit   <= m_start;
                m_done    <= 1'b0;
            end
            else if (m_running && m_sec_hit && m_digit == 3'd0)
            begin
                m_running <= 1'b0;
                m_done    <= 1'b1;
            end
            else if (m_running && m_sec_hit)
                m_digit <= m_digit - 3'd1;
            if (m_scan_hit)
            begin
                m_idx <= m_idx + 3'd1;
                if (m_idx == 3'd7)
                    m_shown <= m_digit;  // frame start
            end
            m_row  <= (m_shown > 3'd5) ? 8'hff : ~(8'h01 << m_idx);
            m_colr <= m_colour[1] ? font[m_shown * 8 + m_idx] : 8'h00;
            m_colg <= m_colour[0] ? font[m_shown * 8 + m_idx] : 8'h00;
        end
    end

    // compare just before the next edge
    always @(posedge clk)
    begin
        #37;
        if (!rst)
        begin
            checks = checks + 1;
            if (digit !== m_digit || done !== m_done)
            begin
                $display("ERR %0t: digit %0d done %b, expected %0d %b",
                         $time, digit, done, m_digit, m_done);
                errors = errors + 1;
            end
            if (row !== m_row)
            begin
                $display("ERR %0t: row %h, expected %h", $time, row, m_row);
                errors = errors + 1;
            end
            if (colr !== m_colr || colg !== m_colg)
            begin
                $display("ERR %0t: colr %h colg %h, expected %h %h",
                         $time, colr, colg, m_colr, m_colg);
                errors = errors + 1;
            end
            if (row !== 8'hff && $countones(~row) != 1)
            begin
                $display("ERR %0t: row %h drives more than one line", $time, row);
                errors = errors + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: countdown still running after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        integer run;
        integer d;
        seed = 32'hc1d6;
        errors = 0;
        checks = 0;
        cycles = 0;
        clk = 1'b0;
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        start = 1'b0;
        load_glyph(0, 64'h3C42_4242_4242_3C00);
        load_glyph(1, 64'h1838_1818_1818_7E00);
        load_glyph(2, 64'h3C66_060C_3060_7E00);
        load_glyph(3, 64'h3C66_061C_0666_3C00);
        load_glyph(4, 64'h0C1C_2C4C_7E0C_0C00);
        load_glyph(5, 64'h7E60_7C06_0666_3C00);
        for (d = 48; d < 64; d++)
            font[d] = 8'h00;  // codes 6 and 7 dark
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (20) wait_cycle();  // dark panel before first start
        for (run = 0; run < RUNS; run++)
        begin
            write_reg(REG_SCAN_DIV, rand_range(0, 3));
            write_reg(REG_SEC_DIV, rand_range(40, 120));
            if (run == 1)
                write_reg(REG_START, rand_range(6, 7));  // above 5, counts from 5
            else
                write_reg(REG_START, rand_range(0, 7));
            if (run == 0 || rand_range(0, 1) == 1)
                write_reg(2'd3, rand_range(0, 65535));  // unused address
            pulse_start();
            if (run == 2 || rand_range(0, 2) == 0)
            begin
                repeat (rand_range(5, 35)) wait_cycle();
                pulse_start();  // restart mid-count
            end
            while (!done)
                wait_cycle();
            repeat (5) wait_cycle();
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dz_countdown.f */
dz_pkg.sv
dz_cfg_regs.sv
dz_tick_gen.sv
dz_countdown.sv
dz_glyph_rom.sv
dz_show.sv
dz_countdown_top.sv
tb_dz_countdown.sv
